/* tb.f */
src/cmd_pkg.sv
src/num_accum.sv
src/keyword_detector.sv
src/cmd_fsm.sv
src/cmd_parser_top.sv
bench/cmd_parser_assert.sv
bench/cmd_parser_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module cmd_parser_tb -f tb.f

./obj_dir/Vcmd_parser_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

/* bench/cmd_parser_tb.sv */
`timescale 1ns/1ps

module cmd_parser_tb;

    localparam int n_rows        = 9;
    localparam int max_elems     = 8;
    localparam int line_timeout  = 400;
    localparam int settle_cycles = 4;

    // row kinds and the strobe that opens a line
    localparam int kind_matrix    = 0;
    localparam int kind_operand   = 1;
    localparam int kind_config    = 2;
    localparam int kind_ignore    = 3;
    localparam int strobe_none    = 0;
    localparam int strobe_start   = 1;
    localparam int strobe_operand = 2;

    logic                                 clk;
    logic                                 rst_n;
    logic [7:0]                           rx_data;
    logic                                 rx_valid;
    logic                                 start_input;
    logic                                 in_operand_select;
    logic [cmd_pkg::dim_w-1:0]            dim_m;
    logic [cmd_pkg::dim_w-1:0]            dim_n;
    logic [7:0]                           elem_data;
    logic                                 write_en;
    logic                                 data_ready;
    logic [cmd_pkg::id_w-1:0]             user_id_a;
    logic [cmd_pkg::id_w-1:0]             user_id_b;
    logic                                 user_input_valid;
    logic                                 config_valid;
    cmd_pkg::cfg_type_t                   config_type;
    logic signed [cmd_pkg::cfg_val_w-1:0] config_value1;
    logic signed [cmd_pkg::cfg_val_w-1:0] config_value2;

    cmd_parser_top dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .start_input       (start_input),
        .in_operand_select (in_operand_select),
        .dim_m             (dim_m),
        .dim_n             (dim_n),
        .elem_data         (elem_data),
        .write_en          (write_en),
        .data_ready        (data_ready),
        .user_id_a         (user_id_a),
        .user_id_b         (user_id_b),
        .user_input_valid  (user_input_valid),
        .config_valid      (config_valid),
        .config_type       (config_type),
        .config_value1     (config_value1),
        .config_value2     (config_value2)
    );

    always #5 clk = ~clk;

    // ========================================
    // command table
    // ========================================
    int         row_kind   [n_rows];
    int         row_strobe [n_rows];
    string      row_text   [n_rows];
    logic [2:0] row_dim_m  [n_rows];
    logic [2:0] row_dim_n  [n_rows];
    logic [7:0] row_elems  [n_rows][max_elems];
    logic [3:0] row_id_a   [n_rows];
    logic [3:0] row_id_b   [n_rows];
    logic [2:0] row_type   [n_rows];
    logic [7:0] row_v1     [n_rows];
    logic [7:0] row_v2     [n_rows];

    // monitor records for the current line
    logic [7:0] elem_q[$];
    logic [3:0] id_a_q[$];
    logic [3:0] id_b_q[$];
    logic [2:0] cfg_type_q[$];
    logic [7:0] cfg_v1_q[$];
    logic [7:0] cfg_v2_q[$];
    int         ready_cnt;
    int         done_events;
    logic [2:0] last_dim_m;
    logic [2:0] last_dim_n;

    int          err_cnt;
    int          timeout_cnt;
    logic [31:0] rng;

    task automatic set_row(input int r, input int kind, input int strobe, input string text,
                           input logic [2:0] dm, input logic [2:0] dn, input logic [3:0] ida,
                           input logic [3:0] idb, input logic [2:0] typ, input logic [7:0] v1,
                           input logic [7:0] v2);
        row_kind[r]   = kind;
        row_strobe[r] = strobe;
        row_text[r]   = text;
        row_dim_m[r]  = dm;
        row_dim_n[r]  = dn;
        row_id_a[r]   = ida;
        row_id_b[r]   = idb;
        row_type[r]   = typ;
        row_v1[r]     = v1;
        row_v2[r]     = v2;
    endtask

    task automatic load_table();
        int r;
        int i;
        for (r = 0; r < n_rows; r++) begin
            for (i = 0; i < max_elems; i++) begin
                row_elems[r][i] = 8'h00;
            end
        end
        set_row(0, kind_matrix, strobe_start, "2 3 1 2 3 4 5 6\n", 2, 3, 0, 0, 0, 0, 0);
        row_elems[0] = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h00, 8'h00};
        set_row(1, kind_operand, strobe_operand, "7 12\r\n", 0, 0, 7, 12, 0, 0, 0);
        set_row(2, kind_config, strobe_none, "CONFIG MAX 5\n", 0, 0, 0, 0,
                cmd_pkg::cfg_max, 8'h05, 8'h00);
        set_row(3, kind_config, strobe_none, "CONFIG COUNT 15\r\n", 0, 0, 0, 0,
                cmd_pkg::cfg_count, 8'h0f, 8'h00);
        set_row(4, kind_config, strobe_none, "CONFIG SCALAR -5\n", 0, 0, 0, 0,
                cmd_pkg::cfg_scalar, 8'hfb, 8'h00);
        set_row(5, kind_config, strobe_none, "CONFIG RANGE -3 20\n", 0, 0, 0, 0,
                cmd_pkg::cfg_range, 8'hfd, 8'h14);
        set_row(6, kind_ignore, strobe_none, "CONFIG SHOW\n", 0, 0, 0, 0, 0, 0, 0);
        set_row(7, kind_ignore, strobe_none, "HELLO 42 -7 CONFIG MA\n", 0, 0, 0, 0, 0, 0, 0);
        // 300 wraps to 44, minus has no effect in a matrix line
        set_row(8, kind_matrix, strobe_start, "1 2 300 -4\n", 1, 2, 0, 0, 0, 0, 0);
        row_elems[8][0] = 8'h2c;
        row_elems[8][1] = 8'h04;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ========================================
    // output monitor
    // ========================================
    always @(negedge clk) begin
        if (rst_n) begin
            if (write_en) begin
                elem_q.push_back(elem_data);
            end
            if (user_input_valid) begin
                id_a_q.push_back(user_id_a);
                id_b_q.push_back(user_id_b);
            end
            if (config_valid) begin
                cfg_type_q.push_back(config_type);
                cfg_v1_q.push_back(config_value1);
                cfg_v2_q.push_back(config_value2);
                done_events++;
            end
            if (data_ready) begin
                ready_cnt++;
                done_events++;
                last_dim_m = dim_m;
                last_dim_n = dim_n;
            end
        end
    end

    task automatic clear_records();
        elem_q.delete();
        id_a_q.delete();
        id_b_q.delete();
        cfg_type_q.delete();
        cfg_v1_q.delete();
        cfg_v2_q.delete();
        ready_cnt   = 0;
        done_events = 0;
    endtask

    // one byte per rx_valid strobe with 0 to 3 idle cycles in between
    task automatic send_line(input int r);
        int i;
        int gap;
        @(negedge clk);
        if (row_strobe[r] != strobe_none) begin
            start_input       = (row_strobe[r] == strobe_start);
            in_operand_select = (row_strobe[r] == strobe_operand);
            @(negedge clk);
            start_input       = 1'b0;
            in_operand_select = 1'b0;
        end
        for (i = 0; i < row_text[r].len(); i++) begin
            rng      = xorshift32(rng);
            gap      = int'(rng[1:0]);
            rx_data  = row_text[r][i];
            rx_valid = 1'b1;
            @(negedge clk);
            rx_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic wait_line_end(output bit ok);
        int cyc;
        ok = 1'b0;
        for (cyc = 0; cyc < line_timeout; cyc++) begin
            @(posedge clk);
            if (done_events != 0) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_row(input int r);
        int n_we;
        int i;
        n_we = (row_kind[r] == kind_matrix) ? int'(row_dim_m[r]) * int'(row_dim_n[r]) : 0;
        check_val("write_en pulses", elem_q.size(), n_we);
        check_val("data_ready pulses", ready_cnt,
                  (row_kind[r] == kind_matrix || row_kind[r] == kind_operand) ? 1 : 0);
        check_val("user_input_valid pulses", id_a_q.size(), (row_kind[r] == kind_operand) ? 1 : 0);
        check_val("config_valid pulses", cfg_type_q.size(), (row_kind[r] == kind_config) ? 1 : 0);
        if (row_kind[r] == kind_matrix) begin
            check_val("dim_m", last_dim_m, row_dim_m[r]);
            check_val("dim_n", last_dim_n, row_dim_n[r]);
            for (i = 0; i < n_we && i < elem_q.size(); i++) begin
                check_val("elem_data", elem_q[i], row_elems[r][i]);
            end
        end
        if (row_kind[r] == kind_operand && id_a_q.size() > 0) begin
            check_val("user_id_a", id_a_q[0], row_id_a[r]);
            check_val("user_id_b", id_b_q[0], row_id_b[r]);
        end
        if (row_kind[r] == kind_config && cfg_type_q.size() > 0) begin
            check_val("config_type", cfg_type_q[0], row_type[r]);
            check_val("config_value1", cfg_v1_q[0], row_v1[r]);
            // second value only means something for RANGE
            if (row_type[r] == cmd_pkg::cfg_range) begin
                check_val("config_value2", cfg_v2_q[0], row_v2[r]);
            end
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        bit ok;
        int r;
        clk               = 1'b0;
        rst_n             = 1'b0;
        rx_data           = 8'h00;
        rx_valid          = 1'b0;
        start_input       = 1'b0;
        in_operand_select = 1'b0;
        err_cnt           = 0;
        timeout_cnt       = 0;
        rng               = 32'd60521;
        last_dim_m        = '0;
        last_dim_n        = '0;
        load_table();
        clear_records();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (r = 0; r < n_rows; r++) begin
            send_line(r);
            if (row_kind[r] != kind_ignore) begin
                wait_line_end(ok);
                if (!ok) begin
                    $display("line %0d (%s) never finished: no data_ready or config_valid",
                             r, row_text[r].substr(0, row_text[r].len() - 2));
                    timeout_cnt++;
                    break;
                end
            end
            // quiet cycles catch any late or extra strobe
            repeat (settle_cycles) @(posedge clk);
            check_row(r);
            clear_records();
        end

        $display("closing: %0d value errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* bench/cmd_parser_assert.sv */
`timescale 1ns/1ps

module cmd_parser_assert (
    input logic clk,
    input logic rst_n,
    input logic write_en,
    input logic data_ready,
    input logic user_input_valid,
    input logic config_valid
);

    // strobes stay low while reset is held
    strobes_low_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(write_en || data_ready || user_input_valid || config_valid))
        else $error("output strobe high during reset");

    // an element write and a config result never share a cycle
    write_cfg_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(write_en && config_valid))
        else $error("write_en and config_valid high together");

    // one data_ready per line
    ready_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        data_ready |=> !data_ready)
        else $error("data_ready high in two consecutive cycles");

endmodule

bind cmd_parser_top cmd_parser_assert cmd_parser_assert_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .write_en         (write_en),
    .data_ready       (data_ready),
    .user_input_valid (user_input_valid),
    .config_valid     (config_valid)
);

/* src/cmd_parser_top.sv */
`timescale 1ns/1ps

module cmd_parser_top #(
    parameter int ELEM_W = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [7:0]                           rx_data,
    input  logic                                 rx_valid,
    input  logic                                 start_input,
    input  logic                                 in_operand_select,
    output logic [cmd_pkg::dim_w-1:0]            dim_m,
    output logic [cmd_pkg::dim_w-1:0]            dim_n,
    output logic [ELEM_W-1:0]                    elem_data,
    output logic                                 write_en,
    output logic                                 data_ready,
    output logic [cmd_pkg::id_w-1:0]             user_id_a,
    output logic [cmd_pkg::id_w-1:0]             user_id_b,
    output logic                                 user_input_valid,
    output logic                                 config_valid,
    output cmd_pkg::cfg_type_t                   config_type,
    output logic signed [cmd_pkg::cfg_val_w-1:0] config_value1,
    output logic signed [cmd_pkg::cfg_val_w-1:0] config_value2
);

    // number path
    logic                     accept;
    logic                     allow_sign;
    logic                     num_done;
    logic signed [ELEM_W-1:0] num_value;

    // keyword path
    logic                     idle;
    logic                     cfg_hit;
    cmd_pkg::cfg_type_t       cfg_type;

    num_accum #(
        .ELEM_W     (ELEM_W)
    ) num_accum_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .accept     (accept),
        .allow_sign (allow_sign),
        .num_done   (num_done),
        .num_value  (num_value)
    );

    keyword_detector keyword_detector_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .idle       (idle),
        .cfg_hit    (cfg_hit),
        .cfg_type   (cfg_type)
    );

    cmd_fsm #(
        .ELEM_W            (ELEM_W)
    ) cmd_fsm_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_input       (start_input),
        .in_operand_select (in_operand_select),
        .num_done          (num_done),
        .num_value         (num_value),
        .cfg_hit           (cfg_hit),
        .cfg_type          (cfg_type),
        .accept            (accept),
        .allow_sign        (allow_sign),
        .idle              (idle),
        .dim_m             (dim_m),
        .dim_n             (dim_n),
        .elem_data         (elem_data),
        .write_en          (write_en),
        .data_ready        (data_ready),
        .user_id_a         (user_id_a),
        .user_id_b         (user_id_b),
        .user_input_valid  (user_input_valid),
        .config_valid      (config_valid),
        .config_type       (config_type),
        .config_value1     (config_value1),
        .config_value2     (config_value2)
    );

endmodule

/* src/cmd_fsm.sv */
`timescale 1ns/1ps

module cmd_fsm #(
    parameter int ELEM_W = 8
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start_input,
    input  logic                                in_operand_select,
    input  logic                                num_done,
    input  logic signed [ELEM_W-1:0]            num_value,
    input  logic                                cfg_hit,
    input  cmd_pkg::cfg_type_t                  cfg_type,
    output logic                                accept,
    output logic                                allow_sign,
    output logic                                idle,
    output logic [cmd_pkg::dim_w-1:0]           dim_m,
    output logic [cmd_pkg::dim_w-1:0]           dim_n,
    output logic [ELEM_W-1:0]                   elem_data,
    output logic                                write_en,
    output logic                                data_ready,
    output logic [cmd_pkg::id_w-1:0]            user_id_a,
    output logic [cmd_pkg::id_w-1:0]            user_id_b,
    output logic                                user_input_valid,
    output logic                                config_valid,
    output cmd_pkg::cfg_type_t                  config_type,
    output logic signed [cmd_pkg::cfg_val_w-1:0] config_value1,
    output logic signed [cmd_pkg::cfg_val_w-1:0] config_value2
);

    // element count reaches rows x cols, at most 7 x 7
    localparam int cnt_w = 2 * cmd_pkg::dim_w;

    cmd_pkg::parse_state_t state;
    cmd_pkg::cfg_type_t    cfg_kind;
    logic [cnt_w-1:0]      elem_cnt;
    logic [cnt_w-1:0]      elem_total;
    logic [cnt_w-1:0]      elem_cnt_inc;
    logic [cnt_w-1:0]      total_now;
    logic [cmd_pkg::dim_w-1:0] dim_val;

    // ========================================
    // state decode for the other blocks
    // ========================================
    assign idle       = (state == cmd_pkg::st_idle);
    assign accept     = (state != cmd_pkg::st_idle) && (state != cmd_pkg::st_done);
    assign allow_sign = (state == cmd_pkg::st_cfg_val1) || (state == cmd_pkg::st_cfg_val2);

    always_comb begin
        dim_val      = num_value[cmd_pkg::dim_w-1:0];
        total_now    = cnt_w'(dim_m) * cnt_w'(dim_val);
        elem_cnt_inc = elem_cnt + 1'b1;
    end

    // ========================================
    // sequencing and output registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= cmd_pkg::st_idle;
            cfg_kind         <= cmd_pkg::cfg_max;
            elem_cnt         <= '0;
            elem_total       <= '0;
            dim_m            <= '0;
            dim_n            <= '0;
            elem_data        <= '0;
            user_id_a        <= '0;
            user_id_b        <= '0;
            config_type      <= cmd_pkg::cfg_max;
            config_value1    <= '0;
            config_value2    <= '0;
            write_en         <= 1'b0;
            data_ready       <= 1'b0;
            user_input_valid <= 1'b0;
            config_valid     <= 1'b0;
        end else begin
            // strobes last one cycle
            write_en         <= 1'b0;
            data_ready       <= 1'b0;
            user_input_valid <= 1'b0;
            config_valid     <= 1'b0;

            case (state)
                cmd_pkg::st_idle: begin
                    elem_cnt <= '0;
                    if (cfg_hit) begin
                        cfg_kind <= cfg_type;
                        state    <= cmd_pkg::st_cfg_val1;
                    end else if (in_operand_select) begin
                        state <= cmd_pkg::st_id_a;
                    end else if (start_input) begin
                        state <= cmd_pkg::st_dim_m;
                    end
                end

                // matrix line: rows, cols, then the elements
                cmd_pkg::st_dim_m: begin
                    if (num_done) begin
                        dim_m <= dim_val;
                        state <= cmd_pkg::st_dim_n;
                    end
                end
                cmd_pkg::st_dim_n: begin
                    if (num_done) begin
                        dim_n      <= dim_val;
                        elem_total <= total_now;
                        if (total_now == '0) begin
                            state <= cmd_pkg::st_done;
                        end else begin
                            state <= cmd_pkg::st_elem;
                        end
                    end
                end
                cmd_pkg::st_elem: begin
                    if (num_done) begin
                        elem_data <= num_value;
                        write_en  <= 1'b1;
                        elem_cnt  <= elem_cnt_inc;
                        if (elem_cnt_inc == elem_total) begin
                            state <= cmd_pkg::st_done;
                        end
                    end
                end

                // operand line: two ids
                cmd_pkg::st_id_a: begin
                    if (num_done) begin
                        user_id_a <= num_value[cmd_pkg::id_w-1:0];
                        state     <= cmd_pkg::st_id_b;
                    end
                end
                cmd_pkg::st_id_b: begin
                    if (num_done) begin
                        user_id_b        <= num_value[cmd_pkg::id_w-1:0];
                        user_input_valid <= 1'b1;
                        state            <= cmd_pkg::st_done;
                    end
                end

                // config values, RANGE takes a second one
                cmd_pkg::st_cfg_val1: begin
                    if (num_done) begin
                        config_value1 <= cmd_pkg::cfg_val_w'(num_value);
                        config_type   <= cfg_kind;
                        if (cfg_kind == cmd_pkg::cfg_range) begin
                            state <= cmd_pkg::st_cfg_val2;
                        end else begin
                            config_valid <= 1'b1;
                            state        <= cmd_pkg::st_idle;
                        end
                    end
                end
                cmd_pkg::st_cfg_val2: begin
                    if (num_done) begin
                        config_value2 <= cmd_pkg::cfg_val_w'(num_value);
                        config_valid  <= 1'b1;
                        state         <= cmd_pkg::st_idle;
                    end
                end

                cmd_pkg::st_done: begin
                    data_ready <= 1'b1;
                    state      <= cmd_pkg::st_idle;
                end

                default: begin
                    state <= cmd_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

/* src/keyword_detector.sv */
`timescale 1ns/1ps

module keyword_detector (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [7:0]            rx_data,
    input  logic                  rx_valid,
    input  logic                  idle,
    output logic                  cfg_hit,
    output cmd_pkg::cfg_type_t    cfg_type
);

    localparam int win_w = cmd_pkg::win_chars * 8;

    // ========================================
    // keyword patterns
    // ========================================
    localparam logic [7*8-1:0] kw_config = {
        cmd_pkg::ascii_c, cmd_pkg::ascii_o, cmd_pkg::ascii_n, cmd_pkg::ascii_f,
        cmd_pkg::ascii_i, cmd_pkg::ascii_g, cmd_pkg::ascii_space
    };
    localparam logic [10*8-1:0] kw_max = {
        kw_config, cmd_pkg::ascii_m, cmd_pkg::ascii_a, cmd_pkg::ascii_x
    };
    localparam logic [12*8-1:0] kw_range = {
        kw_config, cmd_pkg::ascii_r, cmd_pkg::ascii_a, cmd_pkg::ascii_n,
        cmd_pkg::ascii_g, cmd_pkg::ascii_e
    };
    localparam logic [12*8-1:0] kw_count = {
        kw_config, cmd_pkg::ascii_c, cmd_pkg::ascii_o, cmd_pkg::ascii_u,
        cmd_pkg::ascii_n, cmd_pkg::ascii_t
    };
    localparam logic [13*8-1:0] kw_scalar = {
        kw_config, cmd_pkg::ascii_s, cmd_pkg::ascii_c, cmd_pkg::ascii_a,
        cmd_pkg::ascii_l, cmd_pkg::ascii_a, cmd_pkg::ascii_r
    };

    // newest character sits in the low byte
    logic [win_w-1:0]   win;
    logic [win_w-1:0]   win_next;
    logic               match_max;
    logic               match_range;
    logic               match_count;
    logic               match_scalar;
    logic               hit_now;
    cmd_pkg::cfg_type_t hit_type;

    always_comb begin
        win_next     = {win[win_w-9:0], rx_data};
        match_max    = (win_next[10*8-1:0] == kw_max);
        match_range  = (win_next[12*8-1:0] == kw_range);
        match_count  = (win_next[12*8-1:0] == kw_count);
        match_scalar = (win_next[13*8-1:0] == kw_scalar);

        hit_type = cmd_pkg::cfg_max;
        if (match_range) begin
            hit_type = cmd_pkg::cfg_range;
        end else if (match_count) begin
            hit_type = cmd_pkg::cfg_count;
        end else if (match_scalar) begin
            hit_type = cmd_pkg::cfg_scalar;
        end

        hit_now = rx_valid && idle &&
                  (match_max || match_range || match_count || match_scalar);
    end

    // ========================================
    // window and hit register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win      <= '0;
            cfg_hit  <= 1'b0;
            cfg_type <= cmd_pkg::cfg_max;
        end else begin
            cfg_hit <= hit_now;
            // flush on a hit and outside idle so old text never completes a keyword
            if (!idle || hit_now) begin
                win <= '0;
            end else if (rx_valid) begin
                win <= win_next;
            end
            if (hit_now) begin
                cfg_type <= hit_type;
            end
        end
    end

endmodule

/* src/num_accum.sv */
`timescale 1ns/1ps

module num_accum #(
    parameter int ELEM_W = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [7:0]               rx_data,
    input  logic                     rx_valid,
    input  logic                     accept,
    input  logic                     allow_sign,
    output logic                     num_done,
    output logic signed [ELEM_W-1:0] num_value
);

    // accumulator state
    logic [ELEM_W-1:0] mag;
    logic              seen;
    logic              neg;

    // byte classification
    logic              is_digit;
    logic              is_sep;
    logic              is_minus;
    logic [ELEM_W-1:0] digit_val;
    logic [ELEM_W-1:0] mag_next;

    always_comb begin
        is_digit  = (rx_data >= cmd_pkg::ascii_0) && (rx_data <= cmd_pkg::ascii_9);
        is_sep    = (rx_data == cmd_pkg::ascii_space) ||
                    (rx_data == cmd_pkg::ascii_cr) ||
                    (rx_data == cmd_pkg::ascii_lf);
        is_minus  = (rx_data == cmd_pkg::ascii_minus);
        digit_val = ELEM_W'(rx_data - cmd_pkg::ascii_0);
        // times ten as 8x + 2x, wraps at the width
        mag_next  = (mag << 3) + (mag << 1) + digit_val;
    end

    // a separator only ends a number once a digit has been seen
    assign num_done  = rx_valid && accept && is_sep && seen;
    assign num_value = neg ? -$signed(mag) : $signed(mag);

    // ========================================
    // digit collection
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mag  <= '0;
            seen <= 1'b0;
            neg  <= 1'b0;
        end else if (!accept || num_done) begin
            mag  <= '0;
            seen <= 1'b0;
            neg  <= 1'b0;
        end else if (rx_valid) begin
            if (is_digit) begin
                mag  <= mag_next;
                seen <= 1'b1;
            end else if (is_minus && allow_sign && !seen) begin
                // sign only counts before the first digit
                neg <= 1'b1;
            end
        end
    end

endmodule

/* src/cmd_pkg.sv */
package cmd_pkg;

    // ========================================
    // character codes
    // ========================================
    localparam logic [7:0] ascii_lf    = 8'h0a;
    localparam logic [7:0] ascii_cr    = 8'h0d;
    localparam logic [7:0] ascii_space = 8'h20;
    localparam logic [7:0] ascii_minus = 8'h2d;
    localparam logic [7:0] ascii_0     = 8'h30;
    localparam logic [7:0] ascii_9     = 8'h39;

    // upper case letters used by the config keywords
    localparam logic [7:0] ascii_a     = 8'h41;
    localparam logic [7:0] ascii_c     = 8'h43;
    localparam logic [7:0] ascii_e     = 8'h45;
    localparam logic [7:0] ascii_f     = 8'h46;
    localparam logic [7:0] ascii_g     = 8'h47;
    localparam logic [7:0] ascii_i     = 8'h49;
    localparam logic [7:0] ascii_l     = 8'h4c;
    localparam logic [7:0] ascii_m     = 8'h4d;
    localparam logic [7:0] ascii_n     = 8'h4e;
    localparam logic [7:0] ascii_o     = 8'h4f;
    localparam logic [7:0] ascii_r     = 8'h52;
    localparam logic [7:0] ascii_s     = 8'h53;
    localparam logic [7:0] ascii_t     = 8'h54;
    localparam logic [7:0] ascii_u     = 8'h55;
    localparam logic [7:0] ascii_x     = 8'h58;

    // ========================================
    // field widths
    // ========================================
    localparam int dim_w     = 3;
    localparam int id_w      = 4;
    localparam int cfg_val_w = 8;

    // longest keyword is "CONFIG SCALAR"
    localparam int win_chars = 13;

    // ========================================
    // types
    // ========================================
    typedef enum logic [3:0] {
        st_idle     = 4'd0,
        st_dim_m    = 4'd1,
        st_dim_n    = 4'd2,
        st_elem     = 4'd3,
        st_id_a     = 4'd4,
        st_id_b     = 4'd5,
        st_cfg_val1 = 4'd6,
        st_cfg_val2 = 4'd7,
        st_done     = 4'd8
    } parse_state_t;

    // encoding seen by the matrix unit on config_type
    typedef enum logic [2:0] {
        cfg_max    = 3'd0,
        cfg_range  = 3'd1,
        cfg_count  = 3'd2,
        cfg_scalar = 3'd4
    } cfg_type_t;

endpackage
